// File: Bender.yml
package:
  name: instr_cache

sources:
  - files:
      - source/cachePkg.sv
      - source/cacheFillIf.sv
      - source/cacheMemory.sv
      - source/cacheController.sv
      - source/instrCache.sv
  - target: test
    files:
      - testbench/instrCache_checker.sv
      - testbench/instrCacheTb.sv

// File: source/cacheController.sv
/*
 * Miss FSM for the instruction cache: beat counter, bus request,
 * fill word generation and invalidate gating
 */
`timescale 1ns/100ps

module cacheController (
    input  logic             clk,
    input  logic             reset,
    input  logic             enable,
    input  logic             hit,
    input  cachePkg::setT    missSet,
    input  cachePkg::tagT    missTag,
    input  logic             BusReady,
    input  cachePkg::wordT   HRData,
    input  logic             invalidateReq,
    output logic             invalidate,
    output logic             IStall,
    output logic             HRequestF,
    output cachePkg::offsetT beatOffset,
    cacheFillIf.ctrl         fill
);

    cachePkg::ctrlStateT state;
    cachePkg::ctrlStateT stateNext;

    // Word offset of the next bus beat
    cachePkg::offsetT beatCount;

    // Block under fill, captured at the miss
    cachePkg::setT blockSet;
    cachePkg::tagT blockTag;

    logic isIdle;
    logic missStart;
    logic beatTaken;
    logic lastBeat;
    // Invalidate seen during a fill, waiting for Idle
    logic invPending;

    assign isIdle    = (state == cachePkg::Idle);
    assign missStart = isIdle && enable && !hit;

    // Beat completes on request and ready together
    assign beatTaken = HRequestF && BusReady;
    assign lastBeat  = beatTaken && (beatCount == cachePkg::offsetT'(cachePkg::BlockWords - 1));

    // Next state
    always_comb begin
        stateNext = state;
        unique case (state)
            cachePkg::Idle: begin
                if (missStart) begin
                    stateNext = cachePkg::Fill;
                end
            end
            cachePkg::Fill: begin
                if (lastBeat) begin
                    stateNext = cachePkg::Done;
                end
            end
            cachePkg::Done: begin
                stateNext = cachePkg::Idle;
            end
            default: begin
                stateNext = cachePkg::Idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= cachePkg::Idle;
        end else begin
            state <= stateNext;
        end
    end

    // Beat counter wraps back to 0 after the last word
    always_ff @(posedge clk) begin
        if (reset) begin
            beatCount <= '0;
        end else if (beatTaken) begin
            beatCount <= beatCount + 1'b1;
        end
    end

    // Capture the missing block, held until the next miss
    always_ff @(posedge clk) begin
        if (missStart) begin
            blockSet <= missSet;
            blockTag <= missTag;
        end
    end

    // Hold off invalidate until the FSM is back in Idle
    always_ff @(posedge clk) begin
        if (reset) begin
            invPending <= 1'b0;
        end else if (isIdle) begin
            invPending <= 1'b0;
        end else if (invalidateReq) begin
            invPending <= 1'b1;
        end
    end

    assign invalidate = isIdle && (invalidateReq || invPending);

    // Stall on a miss, and for the whole fill and Done cycle
    assign IStall    = enable && (!isIdle || !hit);
    assign HRequestF = (state == cachePkg::Fill);
    assign beatOffset = beatCount;

    // Every accepted beat becomes one fill write
    assign fill.fillWrite  = beatTaken;
    assign fill.fillDone   = lastBeat;
    assign fill.fillSet    = blockSet;
    assign fill.fillTag    = blockTag;
    assign fill.fillOffset = beatCount;
    assign fill.fillData   = HRData;

endmodule

// File: source/cacheFillIf.sv
/*
 * Block fill path from the miss controller to the cache storage,
 * with one modport per side
 */
`timescale 1ns/100ps

interface cacheFillIf;

    // Write strobe for one word of the block
    logic              fillWrite;
    // Set and tag of the block being filled, held for the whole fill
    cachePkg::setT     fillSet;
    cachePkg::tagT     fillTag;
    // Word position inside the block
    cachePkg::offsetT  fillOffset;
    // Word taken from the bus
    cachePkg::wordT    fillData;
    // Last beat, block becomes valid
    logic              fillDone;
    // Victim way, from the LRU bit of fillSet
    logic              fillWay;

    // Controller side
    modport ctrl (
        output fillWrite,
        output fillSet,
        output fillTag,
        output fillOffset,
        output fillData,
        output fillDone,
        input  fillWay
    );

    // Storage side
    modport mem (
        input  fillWrite,
        input  fillSet,
        input  fillTag,
        input  fillOffset,
        input  fillData,
        input  fillDone,
        output fillWay
    );

endinterface

// File: source/cacheMemory.sv
/*
 * Two-way storage for the instruction cache: valid bits, tags,
 * block words and one LRU bit per set, with hit detection
 */
`timescale 1ns/100ps

module cacheMemory (
    input  logic             clk,
    input  logic             reset,
    input  logic             invalidate,
    input  cachePkg::setT    lookupSet,
    input  cachePkg::tagT    lookupTag,
    input  cachePkg::offsetT lookupOffset,
    output logic             hit,
    output cachePkg::wordT   hitWord,
    cacheFillIf.mem          fill
);

    // Valid bits, indexed [way][set]
    logic [cachePkg::Sets-1:0] valid [2];

    // LRU bit per set names the next victim way
    logic [cachePkg::Sets-1:0] lru;

    // Tag and block storage
    cachePkg::tagT  tagStore  [2][cachePkg::Sets];
    cachePkg::wordT dataStore [2][cachePkg::Sets][cachePkg::BlockWords];

    // Per-way match on the current lookup
    logic [1:0] wayHit;

    // Victim comes straight from the LRU bit of the set under fill
    // Stable during a fill, LRU only moves on fillDone
    assign fill.fillWay = lru[fill.fillSet];

    // Valid bits
    // Victim goes invalid on its first fill word so a half-written
    // block never matches, and valid again on the last word
    always_ff @(posedge clk) begin
        if (reset || invalidate) begin
            valid[0] <= '0;
            valid[1] <= '0;
        end else if (fill.fillWrite) begin
            valid[fill.fillWay][fill.fillSet] <= fill.fillDone;
        end
    end

    // LRU bits, round robin within the set
    always_ff @(posedge clk) begin
        if (reset) begin
            lru <= '0;
        end else if (fill.fillDone) begin
            // Next victim is the way not just filled
            lru[fill.fillSet] <= ~fill.fillWay;
        end
    end

    // Tag and data payload
    always_ff @(posedge clk) begin
        if (fill.fillWrite) begin
            dataStore[fill.fillWay][fill.fillSet][fill.fillOffset] <= fill.fillData;
            // Same tag on every beat of a fill
            tagStore[fill.fillWay][fill.fillSet] <= fill.fillTag;
        end
    end

    // Tag compare on both ways
    always_comb begin
        for (int w = 0; w < 2; w++) begin
            wayHit[w] = valid[w][lookupSet] && (tagStore[w][lookupSet] == lookupTag);
        end
    end

    // At most one way holds a given tag
    assign hit = |wayHit;

    // Word select from the matching way
    // Don't care when there is no hit, the fetch stalls then
    always_comb begin
        if (wayHit[1]) begin
            hitWord = dataStore[1][lookupSet][lookupOffset];
        end else begin
            hitWord = dataStore[0][lookupSet][lookupOffset];
        end
    end

endmodule

// File: source/cachePkg.sv
/*
 * Instruction cache geometry constants, address and data types,
 * and the miss controller state encoding
 */
package cachePkg;

    // Fetch side widths
    localparam int AddrWidth  = 32;
    localparam int WordWidth  = 32;

    // Block and set geometry
    localparam int BlockWords = 4;
    localparam int Sets       = 2;

    // Field widths derived from the geometry
    localparam int BlockBits  = $clog2(BlockWords);
    localparam int SetBits    = $clog2(Sets);
    // Two low bits select the byte within a word
    localparam int TagBits    = AddrWidth - 2 - BlockBits - SetBits;

    // Address and data
    typedef logic [AddrWidth-1:0] addrT;
    typedef logic [WordWidth-1:0] wordT;

    // Fields of a split fetch address
    typedef logic [TagBits-1:0]   tagT;
    typedef logic [SetBits-1:0]   setT;
    typedef logic [BlockBits-1:0] offsetT;

    // Miss handling FSM
    // Idle  serving hits, waiting for a miss
    // Fill  bus request up, one word taken per ready beat
    // Done  block valid, one cycle before returning to Idle
    typedef enum logic [1:0] {
        Idle,
        Fill,
        Done
    } ctrlStateT;

endpackage

// File: source/instrCache.sv
/*
 * Two-way set-associative instruction cache top level,
 * fetch port and bus fill port
 */
`timescale 1ns/100ps

module instrCache (
    input  logic           clk,
    input  logic           reset,
    input  logic           enable,
    input  logic           invalidate,
    input  cachePkg::addrT A,
    input  cachePkg::wordT HRData,
    input  logic           BusReady,
    output cachePkg::wordT RD,
    output cachePkg::addrT HAddrF,
    output logic           IStall,
    output logic           HRequestF
);

    // Fetch address fields
    cachePkg::tagT    fetchTag;
    cachePkg::setT    fetchSet;
    cachePkg::offsetT fetchOffset;

    logic             hit;
    cachePkg::wordT   hitWord;
    // Invalidate after gating by the FSM
    logic             invalidateNow;
    // Word offset of the current bus beat
    cachePkg::offsetT beatOffset;

    // Fill path between controller and storage
    cacheFillIf fillBus ();

    // Split A, byte offset bits are ignored
    assign fetchOffset = A[cachePkg::BlockBits+1:2];
    assign fetchSet    = A[cachePkg::BlockBits+2 +: cachePkg::SetBits];
    assign fetchTag    = A[cachePkg::AddrWidth-1 -: cachePkg::TagBits];

    cacheMemory i_cacheMemory (
        .clk          (clk),
        .reset        (reset),
        .invalidate   (invalidateNow),
        .lookupSet    (fetchSet),
        .lookupTag    (fetchTag),
        .lookupOffset (fetchOffset),
        .hit          (hit),
        .hitWord      (hitWord),
        .fill         (fillBus.mem)
    );

    cacheController i_cacheController (
        .clk           (clk),
        .reset         (reset),
        .enable        (enable),
        .hit           (hit),
        .missSet       (fetchSet),
        .missTag       (fetchTag),
        .BusReady      (BusReady),
        .HRData        (HRData),
        .invalidateReq (invalidate),
        .invalidate    (invalidateNow),
        .IStall        (IStall),
        .HRequestF     (HRequestF),
        .beatOffset    (beatOffset),
        .fill          (fillBus.ctrl)
    );

    // Bus address from the latched block, not from A
    // Stays put under back-pressure even if A moves
    assign HAddrF = {fillBus.fillTag, fillBus.fillSet, beatOffset, 2'b00};

    // Only valid with IStall low
    assign RD = hitWord;

endmodule

// File: src.f
source/cachePkg.sv
source/cacheFillIf.sv
source/cacheMemory.sv
source/cacheController.sv
source/instrCache.sv
testbench/instrCache_checker.sv
testbench/instrCacheTb.sv

// File: testbench/instrCacheTb.sv
/*
 * Random fetch and bus stimulus for the instruction cache, with a
 * reference model of the memory and cache, compare tasks and a timeout
 */
`timescale 1ns/100ps

module instrCacheTb;

    localparam int NumFetches  = 2000;
    localparam int ResetCycles = 16;
    // Generous bound per fetch, covers long BusReady gaps
    localparam int CycleLimit  = NumFetches * 40 + ResetCycles;

    logic           clk;
    logic           reset;
    logic           enable;
    logic           invalidate;
    cachePkg::addrT A;
    cachePkg::wordT HRData;
    logic           BusReady;
    cachePkg::wordT RD;
    cachePkg::addrT HAddrF;
    logic           IStall;
    logic           HRequestF;

    integer seed;
    int     cycleCount;
    int     fetchCount;
    int     hitCount;
    int     missCount;
    int     invCount;
    // Fetch waiting on a miss, A and enable held
    logic   fetchPending;

    // Model of valid, tag and LRU state, indexed [way][set]
    logic                mValid [2][cachePkg::Sets];
    cachePkg::tagT       mTag   [2][cachePkg::Sets];
    logic                mLru   [cachePkg::Sets];
    // Model of the miss FSM
    cachePkg::ctrlStateT mState;
    cachePkg::addrT      missBase;
    int                  mBeat;
    logic                mVictim;
    logic                mInvPend;

    // Three tags sharing two ways per set force evictions
    cachePkg::tagT tagPool [3];

    instrCache i_instrCache (
        .clk        (clk),
        .reset      (reset),
        .enable     (enable),
        .invalidate (invalidate),
        .A          (A),
        .HRData     (HRData),
        .BusReady   (BusReady),
        .RD         (RD),
        .HAddrF     (HAddrF),
        .IStall     (IStall),
        .HRequestF  (HRequestF)
    );

    bind instrCache instrCache_checker i_instrCacheChecker (
        .clk       (clk),
        .reset     (reset),
        .enable    (enable),
        .IStall    (IStall),
        .HRequestF (HRequestF),
        .BusReady  (BusReady),
        .HAddrF    (HAddrF)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Backing memory contents, a fixed function of the word address
    function automatic cachePkg::wordT memWord(input cachePkg::addrT addr);
        memWord = (addr & ~32'h3) ^ 32'hc3a5_1e69 ^ {addr[13:2], 20'h0};
    endfunction

    function automatic cachePkg::addrT blockBase(input cachePkg::addrT addr);
        blockBase = addr & ~cachePkg::addrT'(cachePkg::BlockWords * 4 - 1);
    endfunction

    // Set index sits just above the word offset
    function automatic cachePkg::setT setOf(input cachePkg::addrT addr);
        setOf = addr[cachePkg::BlockBits+2 +: cachePkg::SetBits];
    endfunction

    function automatic cachePkg::tagT tagOf(input cachePkg::addrT addr);
        tagOf = addr[cachePkg::AddrWidth-1 -: cachePkg::TagBits];
    endfunction

    function automatic logic modelHit(input cachePkg::addrT addr);
        modelHit = 1'b0;
        for (int w = 0; w < 2; w++) begin
            if (mValid[w][setOf(addr)] && mTag[w][setOf(addr)] == tagOf(addr)) begin
                modelHit = 1'b1;
            end
        end
    endfunction

    task automatic abortRun();
        $display("Checks failed");
        $fatal(1, "stopped at the first mismatch");
    endtask

    task automatic checkWord(input cachePkg::wordT actual, input cachePkg::wordT expected,
                             input string what);
        if (actual !== expected) begin
            $display("Fail at %0t: %s got %h, expected %h", $time, what, actual, expected);
            abortRun();
        end
    endtask

    task automatic checkAddr(input cachePkg::addrT actual, input cachePkg::addrT expected,
                             input string what);
        if (actual !== expected) begin
            $display("Fail at %0t: %s got %h, expected %h", $time, what, actual, expected);
            abortRun();
        end
    endtask

    task automatic checkStall(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            $display("Fail at %0t: %s got %b, expected %b", $time, what, actual, expected);
            abortRun();
        end
    endtask

    // Bound protocol checker counts its own assertion failures
    task automatic checkProtocol();
        if (i_instrCache.i_instrCacheChecker.failCount != 0) begin
            $display("Protocol assertion on the bus or stall signals failed at %0t", $time);
            abortRun();
        end
    endtask

    // 24 distinct words, word aligned
    task automatic pickAddress(output cachePkg::addrT addr);
        int r;
        r = $random(seed);
        addr = {tagPool[$unsigned(r) % 3], r[10:8], 2'b00};
    endtask

    // Called on the falling edge
    task automatic driveInputs();
        int r;
        if (!fetchPending) begin
            r = $random(seed);
            enable = ($unsigned(r) % 100) < 80;
            pickAddress(A);
        end
        r = $random(seed);
        invalidate = ($unsigned(r) % 100) == 0;
        r = $random(seed);
        BusReady = r[0];
        // Bus answers whatever address the cache puts out
        if (HRequestF) begin
            HRData = memWord(HAddrF);
        end else begin
            HRData = '0;
        end
    endtask

    // Called on the rising edge, sees the values the DUT samples
    task automatic checkAndUpdate();
        logic          predHit;
        cachePkg::setT fillSet;
        predHit = modelHit(A);
        fillSet = setOf(missBase);
        case (mState)
            cachePkg::Idle: begin
                checkStall(HRequestF, 1'b0, "HRequestF outside a fill");
                checkStall(IStall, enable && !predHit, "IStall on fetch");
                if (enable && predHit) begin
                    checkWord(RD, memWord(A), "RD on hit");
                    fetchCount++;
                    hitCount++;
                    fetchPending = 1'b0;
                end else if (enable) begin
                    // Victim is whatever LRU names at the miss
                    missCount++;
                    fetchPending = 1'b1;
                    missBase = blockBase(A);
                    mBeat = 0;
                    mVictim = mLru[setOf(A)];
                    mState = cachePkg::Fill;
                end
                if (invalidate || mInvPend) begin
                    for (int w = 0; w < 2; w++) begin
                        for (int s = 0; s < cachePkg::Sets; s++) begin
                            mValid[w][s] = 1'b0;
                        end
                    end
                    mInvPend = 1'b0;
                    invCount++;
                end
            end
            cachePkg::Fill: begin
                checkStall(IStall, enable, "IStall during fill");
                checkStall(HRequestF, 1'b1, "HRequestF during fill");
                checkAddr(HAddrF, missBase + cachePkg::addrT'(mBeat * 4), "HAddrF on beat");
                if (invalidate) begin
                    mInvPend = 1'b1;
                end
                if (BusReady && mBeat == cachePkg::BlockWords - 1) begin
                    mValid[mVictim][fillSet] = 1'b1;
                    mTag[mVictim][fillSet] = tagOf(missBase);
                    mLru[fillSet] = !mVictim;
                    mState = cachePkg::Done;
                end else if (BusReady) begin
                    mBeat++;
                end
            end
            default: begin
                // Done, one stall cycle after the last beat
                checkStall(IStall, enable, "IStall in the cycle after a fill");
                checkStall(HRequestF, 1'b0, "HRequestF after the last beat");
                if (invalidate) begin
                    mInvPend = 1'b1;
                end
                mState = cachePkg::Idle;
            end
        endcase
    endtask

    // Run limit
    initial begin
        cycleCount = 0;
        while (cycleCount <= CycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Timeout: run did not finish within %0d cycles", CycleLimit);
        $display("Checks failed");
        $fatal(1, "timeout");
    end

    initial begin
        seed = 32'h8af742ea;
        tagPool[0] = 27'h0000123;
        tagPool[1] = 27'h2a5c0f1;
        tagPool[2] = 27'h7ffff3e;
        reset = 1'b1;
        enable = 1'b0;
        invalidate = 1'b0;
        A = '0;
        HRData = '0;
        BusReady = 1'b0;
        fetchPending = 1'b0;
        fetchCount = 0;
        hitCount = 0;
        missCount = 0;
        invCount = 0;
        // Model comes out of reset like the DUT
        mState = cachePkg::Idle;
        mInvPend = 1'b0;
        mBeat = 0;
        mVictim = 1'b0;
        missBase = '0;
        for (int s = 0; s < cachePkg::Sets; s++) begin
            mLru[s] = 1'b0;
            for (int w = 0; w < 2; w++) begin
                mValid[w][s] = 1'b0;
                mTag[w][s] = '0;
            end
        end
        repeat (ResetCycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        while (fetchCount < NumFetches) begin
            driveInputs();
            @(posedge clk);
            checkAndUpdate();
            @(negedge clk);
            checkProtocol();
        end
        $display("%0d fetches, %0d hits, %0d misses, %0d invalidates",
                 fetchCount, hitCount, missCount, invCount);
        $display("All checks passed");
        $finish;
    end

endmodule

// File: testbench/instrCache_checker.sv
/*
 * Bus and stall protocol assertions for the instruction cache,
 * bound to the top level
 */
`timescale 1ns/100ps

module instrCache_checker (
    input logic           clk,
    input logic           reset,
    input logic           enable,
    input logic           IStall,
    input logic           HRequestF,
    input logic           BusReady,
    input cachePkg::addrT HAddrF
);

    // Number of assertion failures so far
    int failCount;

    initial begin
        failCount = 0;
    end

    // A running fill means the fetch must wait
    property requestStalls;
        @(posedge clk) disable iff (reset) (enable && HRequestF) |-> IStall;
    endproperty

    // Address holds under back-pressure
    property addrHeld;
        @(posedge clk) disable iff (reset) (HRequestF && !BusReady) |=> $stable(HAddrF);
    endproperty

    // No request right out of reset
    property quietAfterReset;
        @(posedge clk) reset |=> !HRequestF;
    endproperty

    assert property (requestStalls)
        else begin
            $error("HRequestF high with enable set but IStall low");
            failCount++;
        end
    assert property (addrHeld)
        else begin
            $error("HAddrF moved while BusReady was low");
            failCount++;
        end
    assert property (quietAfterReset)
        else begin
            $error("HRequestF high in the cycle after reset");
            failCount++;
        end

endmodule
